// ==== rtl/hart_mem_macros.svh ====
// ====================
// Address map, widths and depths of the hart memory fabric
// Included by the package and by the RTL that decodes or sizes memory
// ====================
`ifndef HART_MEM_MACROS_SVH
`define HART_MEM_MACROS_SVH

// Hart bus width
`define HM_XLEN 32

// APB address width towards the debug module
`define HM_APB_AW 13

// Program RAM, 4K words from 0x10000
`define HM_RAM_BASE 32'h0001_0000
`define HM_RAM_WORDS 4096
`define HM_RAM_IDX_W 12

// Debug module area, reached over APB in debug mode
`define HM_DBG_START 32'h0000_0200
`define HM_DBG_END 32'h0000_0FFF

// Test exit word
`define HM_TOHOST_ADDR 32'h8000_1000

`endif

// ==== rtl/hart_mem_pkg.sv ====
// ====================
// Shared types of the hart memory fabric
// Imported by the RTL modules and by the testbench
// ====================
`default_nettype none

`include "hart_mem_macros.svh"

package hart_mem_pkg;

  // Hart side words and addresses
  typedef logic [`HM_XLEN-1:0] hm_word_t;
  typedef logic [`HM_XLEN-1:0] hm_addr_t;

  // RAM word index
  typedef logic [`HM_RAM_IDX_W-1:0] ram_idx_t;

  // APB byte address
  typedef logic [`HM_APB_AW-1:0] apb_addr_t;

  // Where an access goes
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_RAM,
    TGT_DEBUG,
    TGT_TOHOST
  } hm_target_t;

  // Fetch bridge payload, reads only
  typedef struct packed {
    apb_addr_t paddr;
  } fetch_apb_req_t;

  // Data bridge payload
  typedef struct packed {
    apb_addr_t paddr;
    logic      pwrite;
    hm_word_t  pwdata;
  } data_apb_req_t;

endpackage

`default_nettype wire

// ==== rtl/hart_addr_decode.sv ====
// ====================
// Input side decode of both hart addresses
// Gives each port a target and a RAM word index
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "hart_mem_macros.svh"

module hart_addr_decode
  import hart_mem_pkg::*;
(
  input  logic       i_debug_mode,
  input  hm_addr_t   i_imem_addr,
  input  hm_addr_t   i_dmem_addr,
  output hm_target_t o_fetch_target,
  output hm_target_t o_data_target,
  output ram_idx_t   o_fetch_idx,
  output ram_idx_t   o_data_idx
);

  // Offsets from the RAM base
  // Addresses below the base wrap to large values and fall out of range
  hm_addr_t fetch_off;
  hm_addr_t data_off;
  logic     fetch_in_ram;
  logic     data_in_ram;
  logic     fetch_in_dbg;
  logic     data_in_dbg;

  assign fetch_off = i_imem_addr - `HM_RAM_BASE;
  assign data_off  = i_dmem_addr - `HM_RAM_BASE;

  assign fetch_in_ram = fetch_off < 32'(`HM_RAM_WORDS * 4);
  assign data_in_ram  = data_off < 32'(`HM_RAM_WORDS * 4);

  // Debug area only exists while the hart is halted
  assign fetch_in_dbg = i_debug_mode &&
                        (i_imem_addr >= `HM_DBG_START) && (i_imem_addr <= `HM_DBG_END);
  assign data_in_dbg  = i_debug_mode &&
                        (i_dmem_addr >= `HM_DBG_START) && (i_dmem_addr <= `HM_DBG_END);

  // ====================
  // Target select
  // ====================
  always_comb
  begin
    // Debug first, then RAM
    if (fetch_in_dbg)
      o_fetch_target = TGT_DEBUG;
    else if (fetch_in_ram)
      o_fetch_target = TGT_RAM;
    else
      o_fetch_target = TGT_NONE;

    // Only the data port can hit tohost
    if (data_in_dbg)
      o_data_target = TGT_DEBUG;
    else if (data_in_ram)
      o_data_target = TGT_RAM;
    else if (i_dmem_addr == `HM_TOHOST_ADDR)
      o_data_target = TGT_TOHOST;
    else
      o_data_target = TGT_NONE;
  end

  // Word index drops the byte offset
  assign o_fetch_idx = fetch_off[`HM_RAM_IDX_W+1:2];
  assign o_data_idx  = data_off[`HM_RAM_IDX_W+1:2];

endmodule

`default_nettype wire

// ==== rtl/debug_apb_bridge.sv ====
// ====================
// APB request FSM for one hart port in debug mode
// Holds a request payload from start until the arbiter reports it done
// ====================
`timescale 1ns/1ps
`default_nettype none

module debug_apb_bridge #(
  parameter type req_t = logic
) (
  input  logic clk,
  input  logic reset_n,
  input  logic i_debug_mode,
  input  logic i_start,
  input  req_t i_req,
  output logic o_req_valid,
  output req_t o_req,
  input  logic i_done
);

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS
  } br_state_t;

  br_state_t state_q;
  br_state_t state_d;

  // ====================
  // Next state
  // ====================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      BR_IDLE:
      begin
        // New request from the hart side
        if (i_start)
          state_d = BR_SETUP;
      end
      BR_SETUP:
      begin
        if (i_done)
          state_d = BR_IDLE;
        else
          state_d = BR_ACCESS;
      end
      BR_ACCESS:
      begin
        // Wait here while the other master owns the bus
        // and during wait states of pready
        if (i_done)
          state_d = BR_IDLE;
      end
      default:
      begin
        state_d = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= BR_IDLE;
    else if (!i_debug_mode)
      // Leaving debug mode drops any request
      state_q <= BR_IDLE;
    else
      state_q <= state_d;
  end

  // Payload captured once per transfer
  always_ff @(posedge clk)
  begin
    if (state_q == BR_IDLE && i_start)
      o_req <= i_req;
  end

  assign o_req_valid = (state_q != BR_IDLE);

endmodule

`default_nettype wire

// ==== rtl/apb_master_arbiter.sv ====
// ====================
// Merges the fetch and data bridges onto the external APB port
// Data wins a tie and the grant is held until pready
// ====================
`timescale 1ns/1ps
`default_nettype none

module apb_master_arbiter
  import hart_mem_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           i_fetch_valid,
  input  fetch_apb_req_t i_fetch_req,
  input  logic           i_data_valid,
  input  data_apb_req_t  i_data_req,
  output logic           o_fetch_done,
  output logic           o_data_done,
  output apb_addr_t      o_apb_paddr,
  output logic           o_apb_psel,
  output logic           o_apb_penable,
  output logic           o_apb_pwrite,
  output hm_word_t       o_apb_pwdata,
  input  logic           i_apb_pready
);

  typedef enum logic {
    ARB_IDLE,
    ARB_ACCESS
  } arb_state_t;

  arb_state_t state_q;
  logic       grant_data_q;
  logic       grant_data;
  logic       xfer_end;

  // Idle picks a master combinationally, access keeps the stored grant
  assign grant_data = (state_q == ARB_IDLE) ? i_data_valid : grant_data_q;

  // ====================
  // APB phases
  // ====================
  // Setup cycle is the idle cycle that sees a request
  assign o_apb_psel    = (state_q == ARB_ACCESS) || i_data_valid || i_fetch_valid;
  assign o_apb_penable = (state_q == ARB_ACCESS);

  // Bridge payloads are registered, so these hold for the transfer
  assign o_apb_paddr  = grant_data ? i_data_req.paddr : i_fetch_req.paddr;
  assign o_apb_pwrite = grant_data && i_data_req.pwrite;
  assign o_apb_pwdata = i_data_req.pwdata;

  assign xfer_end = (state_q == ARB_ACCESS) && i_apb_pready;

  // Done goes to the owner only
  assign o_data_done  = xfer_end && grant_data_q;
  assign o_fetch_done = xfer_end && !grant_data_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q      <= ARB_IDLE;
      grant_data_q <= 1'b0;
    end
    else if (state_q == ARB_IDLE)
    begin
      if (i_data_valid || i_fetch_valid)
      begin
        state_q      <= ARB_ACCESS;
        grant_data_q <= i_data_valid;
      end
    end
    else if (xfer_end)
    begin
      state_q <= ARB_IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/shared_ram.sv ====
// ====================
// Single-port program RAM shared by fetch and data
// Write first, then data read, then fetch; reads return two edges after grant
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "hart_mem_macros.svh"

module shared_ram
  import hart_mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     i_fetch_rd,
  input  ram_idx_t i_fetch_idx,
  input  logic     i_data_rd,
  input  logic     i_data_wr,
  input  ram_idx_t i_data_idx,
  input  hm_word_t i_wdata,
  output hm_word_t o_fetch_rdata,
  output logic     o_fetch_valid,
  output hm_word_t o_data_rdata,
  output logic     o_data_valid
);

  hm_word_t mem [`HM_RAM_WORDS];
  hm_word_t rd_word_q;

  // Granted last cycle, data sits in rd_word_q
  logic     fetch_pend_q;
  logic     data_pend_q;

  logic     fetch_busy;
  logic     data_busy;
  logic     fetch_gnt;
  logic     data_gnt;
  logic     rd_en;
  ram_idx_t ram_idx;

  // In flight from grant through the valid cycle
  assign fetch_busy = fetch_pend_q || o_fetch_valid;
  assign data_busy  = data_pend_q || o_data_valid;

  // ====================
  // Priority arbiter
  // ====================
  always_comb
  begin
    // Data read may ride along with a data write
    data_gnt  = i_data_rd && !data_busy;
    // Fetch only gets an otherwise free cycle
    fetch_gnt = i_fetch_rd && !fetch_busy && !i_data_wr && !data_gnt;
    rd_en     = data_gnt || fetch_gnt;
    ram_idx   = fetch_gnt ? i_fetch_idx : i_data_idx;
  end

  // Array access
  always_ff @(posedge clk)
  begin
    if (i_data_wr)
      mem[i_data_idx] <= i_wdata;
    if (rd_en)
      // Write-first when both land on the data index
      rd_word_q <= (data_gnt && i_data_wr) ? i_wdata : mem[ram_idx];
  end

  // ====================
  // Read return path
  // ====================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      fetch_pend_q  <= 1'b0;
      data_pend_q   <= 1'b0;
      o_fetch_valid <= 1'b0;
      o_data_valid  <= 1'b0;
    end
    else
    begin
      fetch_pend_q  <= fetch_gnt;
      data_pend_q   <= data_gnt;
      o_fetch_valid <= fetch_pend_q;
      o_data_valid  <= data_pend_q;
    end
  end

  // Route the word to the port that was granted
  always_ff @(posedge clk)
  begin
    if (fetch_pend_q)
      o_fetch_rdata <= rd_word_q;
    if (data_pend_q)
      o_data_rdata <= rd_word_q;
  end

endmodule

`default_nettype wire

// ==== rtl/hart_resp_mux.sv ====
// ====================
// Output side of the fabric: per-target responses, request enables and tohost
// ====================
`timescale 1ns/1ps
`default_nettype none

module hart_resp_mux
  import hart_mem_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  hm_target_t i_fetch_target,
  input  hm_target_t i_data_target,
  input  logic       i_imem_rready,
  input  logic       i_dmem_rready,
  input  logic       i_dmem_wvalid,
  input  hm_word_t   i_dmem_wdata,
  input  logic       i_ram_fetch_valid,
  input  hm_word_t   i_ram_fetch_rdata,
  input  logic       i_ram_data_valid,
  input  hm_word_t   i_ram_data_rdata,
  input  logic       i_fetch_done,
  input  logic       i_data_done,
  input  hm_word_t   i_apb_prdata,
  output logic       o_fetch_start,
  output logic       o_data_start,
  output logic       o_ram_fetch_rd,
  output logic       o_ram_data_rd,
  output logic       o_ram_data_wr,
  output hm_word_t   o_imem_rdata,
  output logic       o_imem_rvalid,
  output hm_word_t   o_dmem_rdata,
  output logic       o_dmem_rvalid,
  output logic       o_dmem_wready,
  output hm_word_t   o_tohost
);

  // ====================
  // Request enables
  // ====================
  assign o_fetch_start = i_imem_rready && (i_fetch_target == TGT_DEBUG);
  assign o_data_start  = (i_dmem_rready || i_dmem_wvalid) && (i_data_target == TGT_DEBUG);

  assign o_ram_fetch_rd = i_imem_rready && (i_fetch_target == TGT_RAM);
  assign o_ram_data_rd  = i_dmem_rready && (i_data_target == TGT_RAM);
  assign o_ram_data_wr  = i_dmem_wvalid && (i_data_target == TGT_RAM);

  // ====================
  // Response select
  // ====================
  always_comb
  begin
    o_imem_rvalid = 1'b0;
    o_imem_rdata  = i_ram_fetch_rdata;
    case (i_fetch_target)
      TGT_RAM:   o_imem_rvalid = i_ram_fetch_valid;
      TGT_DEBUG:
      begin
        // APB read data passes straight through in the pready cycle
        o_imem_rvalid = i_fetch_done;
        o_imem_rdata  = i_apb_prdata;
      end
      default:   o_imem_rvalid = 1'b0;
    endcase

    o_dmem_rvalid = 1'b0;
    o_dmem_wready = 1'b0;
    o_dmem_rdata  = i_ram_data_rdata;
    case (i_data_target)
      TGT_RAM:
      begin
        // RAM takes the write in the same cycle
        o_dmem_rvalid = i_ram_data_valid;
        o_dmem_wready = i_dmem_wvalid;
      end
      TGT_DEBUG:
      begin
        // Held wvalid tells a write transfer from a read
        o_dmem_rvalid = i_data_done && !i_dmem_wvalid;
        o_dmem_wready = i_data_done && i_dmem_wvalid;
        o_dmem_rdata  = i_apb_prdata;
      end
      TGT_TOHOST: o_dmem_wready = i_dmem_wvalid;
      default:    o_dmem_wready = 1'b0;
    endcase
  end

  // Test exit register
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (i_dmem_wvalid && (i_data_target == TGT_TOHOST))
      o_tohost <= i_dmem_wdata;
  end

endmodule

`default_nettype wire

// ==== rtl/hart_mem_fabric.sv ====
// ====================
// Top of the hart memory fabric
// Hart ports in, program RAM inside, debug module APB port out
// ====================
`timescale 1ns/1ps
`default_nettype none

module hart_mem_fabric
  import hart_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      i_debug_mode,
  // Instruction port
  input  hm_addr_t  i_imem_addr,
  input  logic      i_imem_rready,
  output hm_word_t  o_imem_rdata,
  output logic      o_imem_rvalid,
  // Data port
  input  hm_addr_t  i_dmem_addr,
  input  logic      i_dmem_wvalid,
  input  hm_word_t  i_dmem_wdata,
  input  logic      i_dmem_rready,
  output hm_word_t  o_dmem_rdata,
  output logic      o_dmem_rvalid,
  output logic      o_dmem_wready,
  output hm_word_t  o_tohost,
  // Debug module APB
  output apb_addr_t o_apb_paddr,
  output logic      o_apb_psel,
  output logic      o_apb_penable,
  output logic      o_apb_pwrite,
  output hm_word_t  o_apb_pwdata,
  input  logic      i_apb_pready,
  input  hm_word_t  i_apb_prdata
);

  hm_target_t     fetch_target;
  hm_target_t     data_target;
  ram_idx_t       fetch_idx;
  ram_idx_t       data_idx;
  logic           fetch_start;
  logic           data_start;
  fetch_apb_req_t fetch_req;
  data_apb_req_t  data_req;
  logic           fetch_apb_valid;
  logic           data_apb_valid;
  fetch_apb_req_t fetch_apb_req;
  data_apb_req_t  data_apb_req;
  logic           fetch_done;
  logic           data_done;
  logic           ram_fetch_rd;
  logic           ram_data_rd;
  logic           ram_data_wr;
  logic           ram_fetch_valid;
  logic           ram_data_valid;
  hm_word_t       ram_fetch_rdata;
  hm_word_t       ram_data_rdata;

  // Bridge payloads from the hart buses
  assign fetch_req.paddr = apb_addr_t'(i_imem_addr);
  assign data_req.paddr  = apb_addr_t'(i_dmem_addr);
  assign data_req.pwrite = i_dmem_wvalid;
  assign data_req.pwdata = i_dmem_wdata;

  // ====================
  // Input side
  // ====================
  hart_addr_decode u_decode (
    .i_debug_mode   (i_debug_mode),
    .i_imem_addr    (i_imem_addr),
    .i_dmem_addr    (i_dmem_addr),
    .o_fetch_target (fetch_target),
    .o_data_target  (data_target),
    .o_fetch_idx    (fetch_idx),
    .o_data_idx     (data_idx)
  );

  // ====================
  // Bridges, arbiter and RAM
  // ====================
  debug_apb_bridge #(.req_t(fetch_apb_req_t)) fetch_bridge (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_start      (fetch_start),
    .i_req        (fetch_req),
    .o_req_valid  (fetch_apb_valid),
    .o_req        (fetch_apb_req),
    .i_done       (fetch_done)
  );

  debug_apb_bridge #(.req_t(data_apb_req_t)) data_bridge (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_start      (data_start),
    .i_req        (data_req),
    .o_req_valid  (data_apb_valid),
    .o_req        (data_apb_req),
    .i_done       (data_done)
  );

  apb_master_arbiter u_apb_arb (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_fetch_valid (fetch_apb_valid),
    .i_fetch_req   (fetch_apb_req),
    .i_data_valid  (data_apb_valid),
    .i_data_req    (data_apb_req),
    .o_fetch_done  (fetch_done),
    .o_data_done   (data_done),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready)
  );

  shared_ram u_ram (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_fetch_rd    (ram_fetch_rd),
    .i_fetch_idx   (fetch_idx),
    .i_data_rd     (ram_data_rd),
    .i_data_wr     (ram_data_wr),
    .i_data_idx    (data_idx),
    .i_wdata       (i_dmem_wdata),
    .o_fetch_rdata (ram_fetch_rdata),
    .o_fetch_valid (ram_fetch_valid),
    .o_data_rdata  (ram_data_rdata),
    .o_data_valid  (ram_data_valid)
  );

  // ====================
  // Output side
  // ====================
  hart_resp_mux u_resp (
    .clk               (clk),
    .reset_n           (reset_n),
    .i_fetch_target    (fetch_target),
    .i_data_target     (data_target),
    .i_imem_rready     (i_imem_rready),
    .i_dmem_rready     (i_dmem_rready),
    .i_dmem_wvalid     (i_dmem_wvalid),
    .i_dmem_wdata      (i_dmem_wdata),
    .i_ram_fetch_valid (ram_fetch_valid),
    .i_ram_fetch_rdata (ram_fetch_rdata),
    .i_ram_data_valid  (ram_data_valid),
    .i_ram_data_rdata  (ram_data_rdata),
    .i_fetch_done      (fetch_done),
    .i_data_done       (data_done),
    .i_apb_prdata      (i_apb_prdata),
    .o_fetch_start     (fetch_start),
    .o_data_start      (data_start),
    .o_ram_fetch_rd    (ram_fetch_rd),
    .o_ram_data_rd     (ram_data_rd),
    .o_ram_data_wr     (ram_data_wr),
    .o_imem_rdata      (o_imem_rdata),
    .o_imem_rvalid     (o_imem_rvalid),
    .o_dmem_rdata      (o_dmem_rdata),
    .o_dmem_rvalid     (o_dmem_rvalid),
    .o_dmem_wready     (o_dmem_wready),
    .o_tohost          (o_tohost)
  );

endmodule

`default_nettype wire

// ==== verification/hart_mem_checker.sv ====
// ====================
// APB and response assertions, bound to the fabric top level
// ====================
`timescale 1ns/1ps
`default_nettype none

module hart_mem_checker
  import hart_mem_pkg::*;
(
  input wire logic      clk,
  input wire logic      reset_n,
  input wire logic      psel,
  input wire logic      penable,
  input wire logic      pwrite,
  input wire apb_addr_t paddr,
  input wire logic      pready,
  input wire logic      imem_rvalid,
  input wire logic      dmem_rvalid
);

  // Access phase only inside a selected transfer
  assert property (@(posedge clk) disable iff (!reset_n) penable |-> psel)
    else $error("penable without psel");

  // Request signals hold until the transfer ends with pready
  assert property (@(posedge clk) disable iff (!reset_n)
    (psel && !(penable && pready)) |=> (psel && $stable(paddr) && $stable(pwrite)))
    else $error("APB request changed before pready");

  // No response in the first cycle out of reset
  assert property (@(posedge clk) $rose(reset_n) |-> (!imem_rvalid && !dmem_rvalid))
    else $error("rvalid high right after reset");

endmodule

bind hart_mem_fabric hart_mem_checker u_checker (
  .clk         (clk),
  .reset_n     (reset_n),
  .psel        (o_apb_psel),
  .penable     (o_apb_penable),
  .pwrite      (o_apb_pwrite),
  .paddr       (o_apb_paddr),
  .pready      (i_apb_pready),
  .imem_rvalid (o_imem_rvalid),
  .dmem_rvalid (o_dmem_rvalid)
);

`default_nettype wire

// ==== verification/tb_hart_mem_fabric.sv ====
// ====================
// Directed tests of the fabric, with a hart driver and an APB slave model
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "hart_mem_macros.svh"

module tb_hart_mem_fabric
  import hart_mem_pkg::*;
;

  logic      clk;
  logic      reset_n;
  logic      debug_mode;
  hm_addr_t  imem_addr;
  logic      imem_rready;
  hm_word_t  imem_rdata;
  logic      imem_rvalid;
  hm_addr_t  dmem_addr;
  logic      dmem_wvalid;
  hm_word_t  dmem_wdata;
  logic      dmem_rready;
  hm_word_t  dmem_rdata;
  logic      dmem_rvalid;
  logic      dmem_wready;
  hm_word_t  tohost;
  apb_addr_t apb_paddr;
  logic      apb_psel;
  logic      apb_penable;
  logic      apb_pwrite;
  hm_word_t  apb_pwdata;
  logic      apb_pready;
  hm_word_t  apb_prdata;

  // APB model state
  integer    seed;
  logic [1:0] wait_cnt;
  logic [1:0] wait_pick;
  hm_word_t  store_data [16];
  apb_addr_t store_tag [16];
  logic      store_ok [16];
  int        apb_count;
  apb_addr_t last_paddr;
  logic      last_pwrite;
  hm_word_t  last_pwdata;

  int errors;
  int tests;
  int passed;

  hart_mem_fabric dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (debug_mode),
    .i_imem_addr   (imem_addr),
    .i_imem_rready (imem_rready),
    .o_imem_rdata  (imem_rdata),
    .o_imem_rvalid (imem_rvalid),
    .i_dmem_addr   (dmem_addr),
    .i_dmem_wvalid (dmem_wvalid),
    .i_dmem_wdata  (dmem_wdata),
    .i_dmem_rready (dmem_rready),
    .o_dmem_rdata  (dmem_rdata),
    .o_dmem_rvalid (dmem_rvalid),
    .o_dmem_wready (dmem_wready),
    .o_tohost      (tohost),
    .o_apb_paddr   (apb_paddr),
    .o_apb_psel    (apb_psel),
    .o_apb_penable (apb_penable),
    .o_apb_pwrite  (apb_pwrite),
    .o_apb_pwdata  (apb_pwdata),
    .i_apb_pready  (apb_pready),
    .i_apb_prdata  (apb_prdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Default read word of the debug module is the inverse of the address
  function automatic hm_word_t apb_default_word(input apb_addr_t addr);
    return hm_word_t'(~addr);
  endfunction

  // ====================
  // APB slave model
  // ====================
  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      apb_pready <= 1'b0;
      apb_prdata <= '0;
      wait_cnt   <= '0;
    end
    else if (apb_psel && !apb_penable)
    begin
      // Setup cycle picks 0 to 3 wait states and the read word
      wait_pick   = 2'($random(seed));
      wait_cnt   <= wait_pick;
      apb_pready <= (wait_pick == 2'd0);
      if (store_ok[apb_paddr[5:2]] && store_tag[apb_paddr[5:2]] == apb_paddr)
        apb_prdata <= store_data[apb_paddr[5:2]];
      else
        apb_prdata <= apb_default_word(apb_paddr);
    end
    else if (apb_psel && apb_penable && apb_pready)
    begin
      // Transfer ends at this edge
      apb_pready  <= 1'b0;
      apb_count   <= apb_count + 1;
      last_paddr  <= apb_paddr;
      last_pwrite <= apb_pwrite;
      last_pwdata <= apb_pwdata;
      if (apb_pwrite)
      begin
        store_ok[apb_paddr[5:2]]   <= 1'b1;
        store_tag[apb_paddr[5:2]]  <= apb_paddr;
        store_data[apb_paddr[5:2]] <= apb_pwdata;
      end
    end
    else if (apb_psel && apb_penable)
    begin
      // Ready rises after the last wait state
      if (wait_cnt == 2'd1)
        apb_pready <= 1'b1;
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic compare_word(input string what, input hm_word_t got, input hm_word_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Target is seen as debug when the model logged new APB transfers
  task automatic compare_target(input string what, input int mark, input hm_target_t exp,
                                input apb_addr_t exp_addr, input logic exp_write);
    hm_target_t seen;
    seen = (apb_count != mark) ? TGT_DEBUG : TGT_NONE;
    if (seen !== exp)
    begin
      $display("[ERROR] %0t %s: target %s, expected %s", $time, what, seen.name(), exp.name());
      errors++;
    end
    else if (exp == TGT_DEBUG && (last_paddr !== exp_addr || last_pwrite !== exp_write))
    begin
      $display("[ERROR] %0t %s: APB addr %h write %b, expected %h %b", $time, what,
               last_paddr, last_pwrite, exp_addr, exp_write);
      errors++;
    end
  endtask

  // ====================
  // Hart driver
  // ====================
  task automatic fetch_word(input hm_addr_t addr, output hm_word_t data);
    int   n;
    logic seen;
    seen = 1'b0;
    data = '0;
    @(posedge clk);
    imem_addr   <= addr;
    imem_rready <= 1'b1;
    for (n = 0; n < 200 && !seen; n++)
    begin
      @(negedge clk);
      if (imem_rvalid)
      begin
        seen = 1'b1;
        data = imem_rdata;
      end
    end
    if (!seen)
    begin
      $display("Timed out waiting for a fetch response from %h at %0t", addr, $time);
      errors++;
    end
    @(posedge clk);
    imem_rready <= 1'b0;
    // Mid cycle, registers and the APB log have taken the last edge
    @(negedge clk);
  endtask

  task automatic load_word(input hm_addr_t addr, output hm_word_t data);
    int   n;
    logic seen;
    seen = 1'b0;
    data = '0;
    @(posedge clk);
    dmem_addr   <= addr;
    dmem_rready <= 1'b1;
    for (n = 0; n < 200 && !seen; n++)
    begin
      @(negedge clk);
      if (dmem_rvalid)
      begin
        seen = 1'b1;
        data = dmem_rdata;
      end
    end
    if (!seen)
    begin
      $display("Timed out waiting for a data read response from %h at %0t", addr, $time);
      errors++;
    end
    @(posedge clk);
    dmem_rready <= 1'b0;
    @(negedge clk);
  endtask

  task automatic store_word(input hm_addr_t addr, input hm_word_t data);
    int   n;
    logic seen;
    seen = 1'b0;
    @(posedge clk);
    dmem_addr   <= addr;
    dmem_wdata  <= data;
    dmem_wvalid <= 1'b1;
    for (n = 0; n < 200 && !seen; n++)
    begin
      @(negedge clk);
      seen = dmem_wready;
    end
    if (!seen)
    begin
      $display("Timed out waiting for write ready at %h at %0t", addr, $time);
      errors++;
    end
    @(posedge clk);
    dmem_wvalid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests++;
    if (errors == errs_at_start)
    begin
      passed++;
      $display("%s: passed", name);
    end
    else
      $display("%s: failed", name);
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic ram_write_read();
    int       e;
    int       i;
    hm_word_t got;
    e = errors;
    for (i = 0; i < 4; i++)
      store_word(`HM_RAM_BASE + 32'(i * 68), 32'hA5000000 + 32'(i));
    for (i = 0; i < 4; i++)
    begin
      load_word(`HM_RAM_BASE + 32'(i * 68), got);
      compare_word("ram read", got, 32'hA5000000 + 32'(i));
    end
    finish_test("ram_write_read", e);
  endtask

  task automatic ram_fetch();
    int       e;
    hm_word_t got;
    e = errors;
    store_word(`HM_RAM_BASE + 32'h200, 32'h00100093);
    fetch_word(`HM_RAM_BASE + 32'h200, got);
    compare_word("fetch after write", got, 32'h00100093);
    finish_test("ram_fetch", e);
  endtask

  task automatic ram_concurrent();
    int       e;
    hm_word_t got_i;
    hm_word_t got_d;
    e = errors;
    store_word(`HM_RAM_BASE + 32'h300, 32'h11112222);
    store_word(`HM_RAM_BASE + 32'h304, 32'h33334444);
    fork
      fetch_word(`HM_RAM_BASE + 32'h300, got_i);
      load_word(`HM_RAM_BASE + 32'h304, got_d);
    join
    compare_word("concurrent fetch", got_i, 32'h11112222);
    compare_word("concurrent load", got_d, 32'h33334444);
    finish_test("ram_concurrent", e);
  endtask

  task automatic debug_fetch();
    int       e;
    int       mark;
    hm_word_t got;
    e = errors;
    @(posedge clk);
    debug_mode <= 1'b1;
    mark = apb_count;
    fetch_word(32'h0000_0300, got);
    compare_target("debug fetch", mark, TGT_DEBUG, 13'h0300, 1'b0);
    if (apb_count != mark + 1)
    begin
      $display("Debug fetch made %0d APB transfers instead of one", apb_count - mark);
      errors++;
    end
    compare_word("debug fetch data", got, apb_default_word(13'h0300));
    finish_test("debug_fetch", e);
  endtask

  task automatic debug_data();
    int       e;
    int       mark;
    hm_word_t got_i;
    hm_word_t got_d;
    e = errors;
    mark = apb_count;
    store_word(32'h0000_0400, 32'hCAFE0001);
    compare_target("debug write", mark, TGT_DEBUG, 13'h0400, 1'b1);
    compare_word("debug write data", last_pwdata, 32'hCAFE0001);
    fork
      load_word(32'h0000_0400, got_d);
      fetch_word(32'h0000_0804, got_i);
    join
    compare_word("debug read back", got_d, 32'hCAFE0001);
    compare_word("debug fetch beside read", got_i, apb_default_word(13'h0804));
    finish_test("debug_data", e);
  endtask

  task automatic tohost_write();
    int       e;
    int       mark;
    hm_word_t got;
    e = errors;
    @(posedge clk);
    debug_mode <= 1'b0;
    store_word(`HM_RAM_BASE + 32'h1000, 32'h5A5A5A5A);
    mark = apb_count;
    store_word(`HM_TOHOST_ADDR, 32'h0000_0001);
    compare_target("tohost write", mark, TGT_NONE, 13'h0, 1'b0);
    compare_word("tohost", tohost, 32'h0000_0001);
    load_word(`HM_RAM_BASE + 32'h1000, got);
    compare_word("ram after tohost", got, 32'h5A5A5A5A);
    finish_test("tohost_write", e);
  endtask

  initial
  begin
    #200000;
    $display("Simulation ran too long without finishing");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    seed        = 32'hee0;
    errors      = 0;
    tests       = 0;
    passed      = 0;
    apb_count   = 0;
    last_paddr  = '0;
    last_pwrite = 1'b0;
    last_pwdata = '0;
    for (int i = 0; i < 16; i++)
      store_ok[i] = 1'b0;
    apb_pready  = 1'b0;
    apb_prdata  = '0;
    reset_n     = 1'b0;
    debug_mode  = 1'b0;
    imem_addr   = '0;
    imem_rready = 1'b0;
    dmem_addr   = '0;
    dmem_wvalid = 1'b0;
    dmem_wdata  = '0;
    dmem_rready = 1'b0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    ram_write_read();
    ram_fetch();
    ram_concurrent();
    debug_fetch();
    debug_data();
    tohost_write();
    $display("Tests run %0d, passed %0d, errors %0d", tests, passed, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/hart_mem_pkg.sv
rtl/hart_addr_decode.sv
rtl/debug_apb_bridge.sv
rtl/apb_master_arbiter.sv
rtl/shared_ram.sv
rtl/hart_resp_mux.sv
rtl/hart_mem_fabric.sv
verification/hart_mem_checker.sv
verification/tb_hart_mem_fabric.sv

// ==== Makefile ====
# Verilator build and run of the hart memory fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_hart_mem_fabric
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
